// File: rtl/bus_pkg.sv
`default_nettype none

package bus_pkg;

  // Data and byte address width
  localparam int XLEN = 32;

  // One select per byte lane
  localparam int SEL_W = XLEN / 8;

  // Word address carried on the bus, byte offset dropped
  localparam int ADR_W = XLEN - 2;

  // On-chip RAM depth in words and its word index width
  localparam int RAM_WORDS = 1024;
  localparam int RAM_AW = $clog2(RAM_WORDS);

  // RAM region, byte addresses, both ends inclusive
  localparam logic [XLEN-1:0] RAM_BASE = 32'h0000_0000;
  localparam logic [XLEN-1:0] RAM_LIMIT = 32'h0000_0FFF;

  // Arbiter owner codes
  localparam int OWN_W = 2;
  localparam logic [OWN_W-1:0] OWN_NONE = 2'd0;
  localparam logic [OWN_W-1:0] OWN_FETCH = 2'd1;
  localparam logic [OWN_W-1:0] OWN_LSU = 2'd2;

endpackage

`default_nettype wire

// File: rtl/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

  // Width of the access size code
  localparam int SIZE_W = 2;

  // Access size codes on word_size_i
  // Code 3 is not listed and behaves as a byte access
  localparam logic [SIZE_W-1:0] SIZE_BYTE = 2'd0;
  localparam logic [SIZE_W-1:0] SIZE_HALF = 2'd1;
  localparam logic [SIZE_W-1:0] SIZE_WORD = 2'd2;

  // Byte offset inside a word, picks the starting lane
  localparam int LANE_W = 2;

  // Bits per lane, used to turn a lane index into a shift
  localparam int LANE_BITS = 8;

endpackage

`default_nettype wire

// File: rtl/rv32i_memory_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module rv32i_memory_pipe
  import bus_pkg::*;
  import lsu_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              clear_i,
  input  logic              data_ready_i,
  input  logic [XLEN-1:0]   data_i,
  output logic [XLEN-1:0]   data_o,
  input  logic [XLEN-1:0]   addr_i,
  input  logic [SIZE_W-1:0] word_size_i,
  input  logic              write_i,
  output logic              busy_o,
  output logic              err_o,
  // Bus master side
  input  logic [XLEN-1:0]   m_dat_i,
  input  logic              m_ack_i,
  input  logic              m_err_i,
  output logic [XLEN-1:0]   m_dat_o,
  output logic [ADR_W-1:0]  m_adr_o,
  output logic              m_cyc_o,
  output logic [SEL_W-1:0]  m_sel_o,
  output logic              m_stb_o,
  output logic              m_we_o
);

  logic [SEL_W-1:0]  sel;
  logic [LANE_W-1:0] lane;
  logic [LANE_W-1:0] lane_q;
  logic [SIZE_W-1:0] size_q;
  logic [XLEN-1:0]   rd_shift;
  logic [XLEN-1:0]   rd_data;
  logic              start;
  logic              done_ack;
  logic              done_err;

  // Only one master per cycle on our side, so cyc follows stb
  assign m_cyc_o = m_stb_o;

  // New access only while no cycle is open
  assign start = data_ready_i & ~m_stb_o;
  assign done_ack = m_stb_o & m_ack_i;
  assign done_err = m_stb_o & m_err_i;

  // Byte selects and first lane from size and low address bits
  // Misaligned offsets are not trapped
  always_comb begin
    case (word_size_i)
      SIZE_HALF: begin
        sel = addr_i[1] ? 4'b1100 : 4'b0011;
        lane = {addr_i[1], 1'b0};
      end
      SIZE_WORD: begin
        sel = '1;
        lane = '0;
      end
      default: begin
        // Byte, also code 3
        sel = 4'b0001 << addr_i[1:0];
        lane = addr_i[1:0];
      end
    endcase
  end

  // Move the addressed lanes of the read word down to bit 0
  assign rd_shift = m_dat_i >> (lane_q * LANE_BITS);

  // Zero extension by the latched size
  always_comb begin
    case (size_q)
      SIZE_HALF: rd_data = XLEN'(rd_shift[15:0]);
      SIZE_WORD: rd_data = rd_shift;
      default:   rd_data = XLEN'(rd_shift[7:0]);
    endcase
  end

  // Cycle control and sticky error
  always_ff @(posedge clk_i) begin
    if (!rst_n_i || clear_i) begin
      m_stb_o <= 1'b0;
      m_we_o <= 1'b0;
      busy_o <= 1'b0;
      err_o <= 1'b0;
    end else if (start) begin
      m_stb_o <= 1'b1;
      m_we_o <= write_i;
      busy_o <= 1'b1;
    end else if (done_ack) begin
      m_stb_o <= 1'b0;
      m_we_o <= 1'b0;
      busy_o <= 1'b0;
    end else if (done_err) begin
      m_stb_o <= 1'b0;
      m_we_o <= 1'b0;
      busy_o <= 1'b0;
      // Stays up until clear_i
      err_o <= 1'b1;
    end
  end

  // Request payload, held steady for the whole cycle
  always_ff @(posedge clk_i) begin
    if (start) begin
      m_adr_o <= addr_i[XLEN-1:2];
      m_sel_o <= sel;
      // Store data steered onto its lanes
      m_dat_o <= data_i << (lane * LANE_BITS);
      lane_q <= lane;
      size_q <= word_size_i;
    end
    // Loads only, stores and errors keep the last value
    if (done_ack && !m_we_o) begin
      data_o <= rd_data;
    end
  end

endmodule

`default_nettype wire

// File: rtl/fetch_port.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_port
  import bus_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             fetch_req_i,
  input  logic [XLEN-1:0]  pc_i,
  output logic [XLEN-1:0]  instr_o,
  output logic             instr_valid_o,
  output logic             fetch_err_o,
  // Bus master side, read only
  input  logic [XLEN-1:0]  m_dat_i,
  input  logic             m_ack_i,
  input  logic             m_err_i,
  output logic [ADR_W-1:0] m_adr_o,
  output logic             m_cyc_o,
  output logic             m_stb_o
);

  assign m_cyc_o = m_stb_o;

  // Open a cycle on request, close it on ack or err
  // Requests during an open cycle are dropped
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      m_stb_o <= 1'b0;
      instr_valid_o <= 1'b0;
      fetch_err_o <= 1'b0;
    end else begin
      // Completion flags are single-cycle pulses
      instr_valid_o <= 1'b0;
      fetch_err_o <= 1'b0;
      if (fetch_req_i && !m_stb_o) begin
        m_stb_o <= 1'b1;
      end else if (m_stb_o && m_ack_i) begin
        m_stb_o <= 1'b0;
        instr_valid_o <= 1'b1;
      end else if (m_stb_o && m_err_i) begin
        m_stb_o <= 1'b0;
        fetch_err_o <= 1'b1;
      end
    end
  end

  // Word address and fetched word
  always_ff @(posedge clk_i) begin
    if (fetch_req_i && !m_stb_o) begin
      m_adr_o <= pc_i[XLEN-1:2];
    end
    if (m_stb_o && m_ack_i) begin
      instr_o <= m_dat_i;
    end
  end

endmodule

`default_nettype wire

// File: rtl/bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter
  import bus_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_n_i,
  // Fetch master
  input  logic             f_cyc_i,
  input  logic             f_stb_i,
  input  logic [ADR_W-1:0] f_adr_i,
  output logic             f_ack_o,
  output logic             f_err_o,
  // Load/store master
  input  logic             l_cyc_i,
  input  logic             l_stb_i,
  input  logic             l_we_i,
  input  logic [ADR_W-1:0] l_adr_i,
  input  logic [SEL_W-1:0] l_sel_i,
  input  logic [XLEN-1:0]  l_dat_i,
  output logic             l_ack_o,
  output logic             l_err_o,
  // Read data back to both masters
  output logic [XLEN-1:0]  m_dat_o,
  // Shared bus
  input  logic [XLEN-1:0]  s_dat_i,
  input  logic             s_ack_i,
  input  logic             s_err_i,
  output logic             s_cyc_o,
  output logic             s_stb_o,
  output logic             s_we_o,
  output logic [ADR_W-1:0] s_adr_o,
  output logic [SEL_W-1:0] s_sel_o,
  output logic [XLEN-1:0]  s_dat_o
);

  logic [OWN_W-1:0] owner_q;
  logic [OWN_W-1:0] owner_d;

  // Owner keeps the bus while its cyc is up
  // Once free, fetch wins over the load/store unit
  always_comb begin
    owner_d = owner_q;
    if (!(owner_q == OWN_FETCH && f_cyc_i) && !(owner_q == OWN_LSU && l_cyc_i)) begin
      if (f_cyc_i) begin
        owner_d = OWN_FETCH;
      end else if (l_cyc_i) begin
        owner_d = OWN_LSU;
      end else begin
        owner_d = OWN_NONE;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      owner_q <= OWN_NONE;
    end else begin
      owner_q <= owner_d;
    end
  end

  // Steer the owner onto the bus
  always_comb begin
    case (owner_q)
      OWN_FETCH: begin
        // Fetch is always a full-word read
        s_cyc_o = f_cyc_i;
        s_stb_o = f_stb_i;
        s_we_o = 1'b0;
        s_adr_o = f_adr_i;
        s_sel_o = '1;
        s_dat_o = '0;
      end
      OWN_LSU: begin
        s_cyc_o = l_cyc_i;
        s_stb_o = l_stb_i;
        s_we_o = l_we_i;
        s_adr_o = l_adr_i;
        s_sel_o = l_sel_i;
        s_dat_o = l_dat_i;
      end
      default: begin
        s_cyc_o = 1'b0;
        s_stb_o = 1'b0;
        s_we_o = 1'b0;
        s_adr_o = '0;
        s_sel_o = '0;
        s_dat_o = '0;
      end
    endcase
  end

  // Responses go only to the owner
  assign f_ack_o = s_ack_i & (owner_q == OWN_FETCH);
  assign f_err_o = s_err_i & (owner_q == OWN_FETCH);
  assign l_ack_o = s_ack_i & (owner_q == OWN_LSU);
  assign l_err_o = s_err_i & (owner_q == OWN_LSU);
  assign m_dat_o = s_dat_i;

endmodule

`default_nettype wire

// File: rtl/slave_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module slave_decoder
  import bus_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_n_i,
  // Shared bus from the arbiter
  input  logic             s_cyc_i,
  input  logic             s_stb_i,
  input  logic [ADR_W-1:0] s_adr_i,
  output logic             s_ack_o,
  output logic             s_err_o,
  output logic [XLEN-1:0]  s_dat_o,
  // RAM slave
  input  logic             ram_ack_i,
  input  logic [XLEN-1:0]  ram_dat_i,
  output logic             ram_stb_o
);

  logic [XLEN-1:0] byte_adr;
  logic            ram_hit;
  logic            req;
  logic            err_q;

  // Back to a byte address for the region compare
  assign byte_adr = {s_adr_i, 2'b00};
  assign ram_hit = (byte_adr >= RAM_BASE) && (byte_adr <= RAM_LIMIT);
  assign req = s_cyc_i & s_stb_i;

  assign ram_stb_o = req & ram_hit;

  // Unmapped address answers with one err cycle
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      err_q <= 1'b0;
    end else begin
      err_q <= req & ~ram_hit & ~err_q;
    end
  end

  // RAM is the only real slave
  assign s_ack_o = ram_ack_i;
  assign s_err_o = err_q;
  assign s_dat_o = ram_dat_i;

endmodule

`default_nettype wire

// File: rtl/wb_ram.sv
`timescale 1ns/1ps
`default_nettype none

module wb_ram
  import bus_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              stb_i,
  input  logic              we_i,
  input  logic [RAM_AW-1:0] adr_i,
  input  logic [SEL_W-1:0]  sel_i,
  input  logic [XLEN-1:0]   dat_i,
  output logic [XLEN-1:0]   dat_o,
  output logic              ack_o
);

  logic [XLEN-1:0] mem [RAM_WORDS];
  logic            access;

  // Act once per strobe, on the edge that raises ack
  assign access = stb_i & ~ack_o;

  // Ack for one cycle, the next edge clears it
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ack_o <= 1'b0;
    end else begin
      ack_o <= access;
    end
  end

  // Lane-masked write or registered read
  always_ff @(posedge clk_i) begin
    if (access) begin
      if (we_i) begin
        for (int i = 0; i < SEL_W; i++) begin
          if (sel_i[i]) begin
            mem[adr_i][i*8 +: 8] <= dat_i[i*8 +: 8];
          end
        end
      end else begin
        // Full word, the master picks its lanes
        dat_o <= mem[adr_i];
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/mem_subsystem_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_top
  import bus_pkg::*;
  import lsu_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              clear_i,
  // Load/store access
  input  logic              data_ready_i,
  input  logic [XLEN-1:0]   data_i,
  input  logic [XLEN-1:0]   addr_i,
  input  logic [SIZE_W-1:0] word_size_i,
  input  logic              write_i,
  output logic [XLEN-1:0]   data_o,
  output logic              busy_o,
  output logic              err_o,
  // Instruction fetch
  input  logic              fetch_req_i,
  input  logic [XLEN-1:0]   pc_i,
  output logic [XLEN-1:0]   instr_o,
  output logic              instr_valid_o,
  output logic              fetch_err_o
);

  // Load/store master
  logic             l_cyc;
  logic             l_stb;
  logic             l_we;
  logic [ADR_W-1:0] l_adr;
  logic [SEL_W-1:0] l_sel;
  logic [XLEN-1:0]  l_wdat;
  logic             l_ack;
  logic             l_err;
  // Fetch master
  logic             f_cyc;
  logic             f_stb;
  logic [ADR_W-1:0] f_adr;
  logic             f_ack;
  logic             f_err;
  // Read data shared by both masters
  logic [XLEN-1:0]  m_rdat;
  // Shared bus after the arbiter
  logic             s_cyc;
  logic             s_stb;
  logic             s_we;
  logic [ADR_W-1:0] s_adr;
  logic [SEL_W-1:0] s_sel;
  logic [XLEN-1:0]  s_wdat;
  logic [XLEN-1:0]  s_rdat;
  logic             s_ack;
  logic             s_err;
  // RAM side
  logic             ram_stb;
  logic             ram_ack;
  logic [XLEN-1:0]  ram_rdat;

  rv32i_memory_pipe memory_pipe_i (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .clear_i      (clear_i),
    .data_ready_i (data_ready_i),
    .data_i       (data_i),
    .data_o       (data_o),
    .addr_i       (addr_i),
    .word_size_i  (word_size_i),
    .write_i      (write_i),
    .busy_o       (busy_o),
    .err_o        (err_o),
    .m_dat_i      (m_rdat),
    .m_ack_i      (l_ack),
    .m_err_i      (l_err),
    .m_dat_o      (l_wdat),
    .m_adr_o      (l_adr),
    .m_cyc_o      (l_cyc),
    .m_sel_o      (l_sel),
    .m_stb_o      (l_stb),
    .m_we_o       (l_we)
  );

  fetch_port fetch_port_i (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .fetch_req_i   (fetch_req_i),
    .pc_i          (pc_i),
    .instr_o       (instr_o),
    .instr_valid_o (instr_valid_o),
    .fetch_err_o   (fetch_err_o),
    .m_dat_i       (m_rdat),
    .m_ack_i       (f_ack),
    .m_err_i       (f_err),
    .m_adr_o       (f_adr),
    .m_cyc_o       (f_cyc),
    .m_stb_o       (f_stb)
  );

  bus_arbiter bus_arbiter_i (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .f_cyc_i (f_cyc),
    .f_stb_i (f_stb),
    .f_adr_i (f_adr),
    .f_ack_o (f_ack),
    .f_err_o (f_err),
    .l_cyc_i (l_cyc),
    .l_stb_i (l_stb),
    .l_we_i  (l_we),
    .l_adr_i (l_adr),
    .l_sel_i (l_sel),
    .l_dat_i (l_wdat),
    .l_ack_o (l_ack),
    .l_err_o (l_err),
    .m_dat_o (m_rdat),
    .s_dat_i (s_rdat),
    .s_ack_i (s_ack),
    .s_err_i (s_err),
    .s_cyc_o (s_cyc),
    .s_stb_o (s_stb),
    .s_we_o  (s_we),
    .s_adr_o (s_adr),
    .s_sel_o (s_sel),
    .s_dat_o (s_wdat)
  );

  slave_decoder slave_decoder_i (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .s_cyc_i   (s_cyc),
    .s_stb_i   (s_stb),
    .s_adr_i   (s_adr),
    .s_ack_o   (s_ack),
    .s_err_o   (s_err),
    .s_dat_o   (s_rdat),
    .ram_ack_i (ram_ack),
    .ram_dat_i (ram_rdat),
    .ram_stb_o (ram_stb)
  );

  // RAM region is aligned to its size, low word bits index it
  wb_ram wb_ram_i (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .stb_i   (ram_stb),
    .we_i    (s_we),
    .adr_i   (s_adr[RAM_AW-1:0]),
    .sel_i   (s_sel),
    .dat_i   (s_wdat),
    .dat_o   (ram_rdat),
    .ack_o   (ram_ack)
  );

endmodule

`default_nettype wire

// File: bench/tb_mem_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsystem
  import bus_pkg::*;
  import lsu_pkg::*;
();

  // Cycles any single wait may take
  localparam int MAX_WAIT = 64;

  logic              clk_i;
  logic              rst_n_i;
  logic              clear_i;
  logic              data_ready_i;
  logic [XLEN-1:0]   data_i;
  logic [XLEN-1:0]   addr_i;
  logic [SIZE_W-1:0] word_size_i;
  logic              write_i;
  logic              fetch_req_i;
  logic [XLEN-1:0]   pc_i;
  logic [XLEN-1:0]   data_o;
  logic              busy_o;
  logic              err_o;
  logic [XLEN-1:0]   instr_o;
  logic              instr_valid_o;
  logic              fetch_err_o;

  // Byte image of the RAM
  logic [7:0]      ref_mem [RAM_WORDS*SEL_W];
  integer          seed;
  logic [XLEN-1:0] rnd;
  logic [XLEN-1:0] rnd2;
  logic [XLEN-1:0] adr;
  logic [XLEN-1:0] addr_q [$];

  mem_subsystem_top mem_subsystem_top_i (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .clear_i       (clear_i),
    .data_ready_i  (data_ready_i),
    .data_i        (data_i),
    .addr_i        (addr_i),
    .word_size_i   (word_size_i),
    .write_i       (write_i),
    .data_o        (data_o),
    .busy_o        (busy_o),
    .err_o         (err_o),
    .fetch_req_i   (fetch_req_i),
    .pc_i          (pc_i),
    .instr_o       (instr_o),
    .instr_valid_o (instr_valid_o),
    .fetch_err_o   (fetch_err_o)
  );

  // 100 ns period
  always #50 clk_i = ~clk_i;

  // Both halves of the fill value follow the byte address
  function automatic logic [XLEN-1:0] fill_word(input logic [XLEN-1:0] a);
    return {a[15:0] ^ 16'hA5C3, a[15:0]};
  endfunction

  // Load value as the pipe should return it with zero extension
  function automatic logic [XLEN-1:0] expected_load(input logic [XLEN-1:0] a,
                                                     input logic [SIZE_W-1:0] size);
    logic [RAM_AW-1:0] w;
    w = a[RAM_AW+1:2];
    case (size)
      SIZE_WORD: return {ref_mem[{w, 2'd3}], ref_mem[{w, 2'd2}],
                         ref_mem[{w, 2'd1}], ref_mem[{w, 2'd0}]};
      // Half word sits on lanes 0 and 1 or 2 and 3 and ignores address bit 0
      SIZE_HALF: return {16'h0, ref_mem[{w, a[1], 1'b1}], ref_mem[{w, a[1], 1'b0}]};
      // Byte and code 3
      default:   return {24'h0, ref_mem[{w, a[1:0]}]};
    endcase
  endfunction

  // Stores use the same lane rule with the low data bits on the addressed lanes
  function automatic void model_store(input logic [XLEN-1:0] a,
                                      input logic [SIZE_W-1:0] size,
                                      input logic [XLEN-1:0] d);
    logic [RAM_AW-1:0] w;
    w = a[RAM_AW+1:2];
    case (size)
      SIZE_WORD: begin
        ref_mem[{w, 2'd0}] = d[7:0];
        ref_mem[{w, 2'd1}] = d[15:8];
        ref_mem[{w, 2'd2}] = d[23:16];
        ref_mem[{w, 2'd3}] = d[31:24];
      end
      SIZE_HALF: begin
        ref_mem[{w, a[1], 1'b0}] = d[7:0];
        ref_mem[{w, a[1], 1'b1}] = d[15:8];
      end
      default: ref_mem[{w, a[1:0]}] = d[7:0];
    endcase
  endfunction

  // Stops the run on the first problem
  task automatic stop_run(input string what);
    $display("%s", what);
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_data(input string name, input logic [XLEN-1:0] expected,
                            input logic [XLEN-1:0] actual);
    if (actual !== expected) begin
      stop_run($sformatf("mismatch %s expected %h actual %h", name, expected, actual));
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      stop_run($sformatf("mismatch %s expected %b actual %b", name, expected, actual));
    end
  endtask

  task automatic wait_busy_low(input string name);
    int n;
    n = 0;
    @(negedge clk_i);
    while (busy_o && n < MAX_WAIT) begin
      @(negedge clk_i);
      n++;
    end
    if (busy_o) begin
      stop_run($sformatf("%s: busy_o never fell, access did not finish", name));
    end
  endtask

  // Presents one access on data_ready_i and checks that the pipe took it
  task automatic issue_access(input string name, input logic wr, input logic [XLEN-1:0] a,
                              input logic [SIZE_W-1:0] size, input logic [XLEN-1:0] wdata);
    @(posedge clk_i);
    #1;
    data_ready_i = 1'b1;
    write_i = wr;
    addr_i = a;
    word_size_i = size;
    data_i = wdata;
    @(posedge clk_i);
    #1;
    data_ready_i = 1'b0;
    check_flag({name, " busy_o rise"}, 1'b1, busy_o);
  endtask

  // One load or store through data_ready_i
  task automatic run_access(input string name, input logic wr, input logic [XLEN-1:0] a,
                            input logic [SIZE_W-1:0] size, input logic [XLEN-1:0] wdata);
    issue_access(name, wr, a, size, wdata);
    wait_busy_low(name);
  endtask

  task automatic write_mem(input string name, input logic [XLEN-1:0] a,
                           input logic [SIZE_W-1:0] size, input logic [XLEN-1:0] d);
    run_access(name, 1'b1, a, size, d);
    model_store(a, size, d);
  endtask

  task automatic read_and_compare(input string name, input logic [XLEN-1:0] a,
                                  input logic [SIZE_W-1:0] size);
    run_access(name, 1'b0, a, size, '0);
    check_data(name, expected_load(a, size), data_o);
  endtask

  // Raises clear_i while a load is still open on the bus
  task automatic clear_open_load(input string name, input logic [XLEN-1:0] a);
    issue_access(name, 1'b0, a, SIZE_WORD, '0);
    clear_i = 1'b1;
    @(posedge clk_i);
    #1;
    clear_i = 1'b0;
    check_flag({name, " err_o"}, 1'b0, err_o);
    check_flag({name, " busy_o"}, 1'b0, busy_o);
  endtask

  // Single fetch that ends in a word or an error pulse
  task automatic fetch_word(input string name, input logic [XLEN-1:0] pc,
                            input logic expect_err);
    int n;
    @(posedge clk_i);
    #1;
    fetch_req_i = 1'b1;
    pc_i = pc;
    @(posedge clk_i);
    #1;
    fetch_req_i = 1'b0;
    n = 0;
    @(negedge clk_i);
    while (!instr_valid_o && !fetch_err_o && n < MAX_WAIT) begin
      @(negedge clk_i);
      n++;
    end
    if (!instr_valid_o && !fetch_err_o) begin
      stop_run($sformatf("%s: fetch never completed", name));
    end
    check_flag({name, " fetch_err_o"}, expect_err, fetch_err_o);
    if (!expect_err) begin
      check_data({name, " instr_o"}, expected_load(pc, SIZE_WORD), instr_o);
    end
  endtask

  // Fetch pulse and load request on the same edge
  task automatic fetch_during_load(input string name, input logic [XLEN-1:0] pc,
                                   input logic [XLEN-1:0] a, input logic [SIZE_W-1:0] size);
    int   n;
    logic got_instr;
    logic got_data;
    @(posedge clk_i);
    #1;
    data_ready_i = 1'b1;
    write_i = 1'b0;
    addr_i = a;
    word_size_i = size;
    fetch_req_i = 1'b1;
    pc_i = pc;
    @(posedge clk_i);
    #1;
    data_ready_i = 1'b0;
    fetch_req_i = 1'b0;
    check_flag({name, " busy_o rise"}, 1'b1, busy_o);
    got_instr = 1'b0;
    got_data = 1'b0;
    n = 0;
    while (!(got_instr && got_data) && n < MAX_WAIT) begin
      @(negedge clk_i);
      if (fetch_err_o) begin
        stop_run($sformatf("%s: fetch ended in an error", name));
      end
      // Valid pulse lasts a single cycle
      if (instr_valid_o && !got_instr) begin
        got_instr = 1'b1;
        check_data({name, " instr_o"}, expected_load(pc, SIZE_WORD), instr_o);
      end
      if (!busy_o && !got_data) begin
        got_data = 1'b1;
        check_data({name, " data_o"}, expected_load(a, size), data_o);
      end
      n++;
    end
    if (!(got_instr && got_data)) begin
      stop_run($sformatf("%s: fetch or load never completed", name));
    end
  endtask

  initial begin
    seed = 15;
    clk_i = 1'b0;
    rst_n_i = 1'b0;
    clear_i = 1'b0;
    data_ready_i = 1'b0;
    data_i = '0;
    addr_i = '0;
    word_size_i = SIZE_WORD;
    write_i = 1'b0;
    fetch_req_i = 1'b0;
    pc_i = '0;
    repeat (4) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;

    // Outputs quiet after reset
    @(negedge clk_i);
    check_flag("reset busy_o", 1'b0, busy_o);
    check_flag("reset err_o", 1'b0, err_o);
    check_flag("reset instr_valid_o", 1'b0, instr_valid_o);
    check_flag("reset fetch_err_o", 1'b0, fetch_err_o);

    // Fill the RAM so every later load has a known value
    for (int i = 0; i < RAM_WORDS; i++) begin
      adr = XLEN'(i) << 2;
      write_mem("fill", adr, SIZE_WORD, fill_word(adr));
    end

    // Random word stores, then reads of the same words
    for (int i = 0; i < 16; i++) begin
      rnd = $random(seed);
      rnd2 = $random(seed);
      adr = XLEN'({rnd[RAM_AW+1:2], 2'b00});
      addr_q.push_back(adr);
      write_mem($sformatf("word store %0d", i), adr, SIZE_WORD, rnd2);
    end
    foreach (addr_q[k]) begin
      read_and_compare($sformatf("word load %0d", k), addr_q[k], SIZE_WORD);
    end

    // Narrow stores and loads at every lane offset
    for (int off = 0; off < 4; off++) begin
      rnd = $random(seed);
      rnd2 = $random(seed);
      adr = XLEN'({rnd[RAM_AW+1:2], 2'b00}) + XLEN'(off);
      write_mem($sformatf("byte store off %0d", off), adr, SIZE_BYTE, rnd2);
      read_and_compare($sformatf("byte word readback off %0d", off), adr, SIZE_WORD);
      read_and_compare($sformatf("byte load off %0d", off), adr, SIZE_BYTE);
      read_and_compare($sformatf("size 3 load off %0d", off), adr, 2'd3);
      write_mem($sformatf("half store off %0d", off), adr, SIZE_HALF, ~rnd2);
      read_and_compare($sformatf("half word readback off %0d", off), adr, SIZE_WORD);
      read_and_compare($sformatf("half load off %0d", off), adr, SIZE_HALF);
    end

    // Fetch of stored words alone and next to a load
    fetch_word("fetch stored word", addr_q[2], 1'b0);
    fetch_during_load("fetch with load", addr_q[3], addr_q[4], SIZE_WORD);
    fetch_during_load("fetch with byte load", addr_q[5], addr_q[6] + 32'd1, SIZE_BYTE);

    // Unmapped access, sticky error and clear
    read_and_compare("error setup load", addr_q[0], SIZE_WORD);
    rnd = $random(seed);
    adr = RAM_LIMIT + 32'd1 + XLEN'({rnd[15:2], 2'b00});
    run_access("unmapped load", 1'b0, adr, SIZE_WORD, '0);
    check_flag("unmapped load err_o", 1'b1, err_o);
    check_data("unmapped load data_o", expected_load(addr_q[0], SIZE_WORD), data_o);
    read_and_compare("sticky load", addr_q[1], SIZE_WORD);
    check_flag("err_o sticky", 1'b1, err_o);
    clear_open_load("first clear", addr_q[0]);
    run_access("unmapped store", 1'b1, adr, SIZE_WORD, rnd);
    check_flag("unmapped store err_o", 1'b1, err_o);
    // RAM alias of that address must not have been written
    read_and_compare("alias untouched", XLEN'(adr[RAM_AW+1:0]), SIZE_WORD);
    clear_open_load("second clear", addr_q[0]);
    fetch_word("unmapped fetch", adr, 1'b1);
    check_flag("fetch error leaves err_o", 1'b0, err_o);

    // Random mix of stores, loads and fetches
    for (int i = 0; i < 60; i++) begin
      rnd = $random(seed);
      rnd2 = $random(seed);
      adr = XLEN'(rnd[RAM_AW+1:0]);
      case (rnd[31:30])
        2'd0: write_mem($sformatf("mixed store %0d", i), adr, rnd[29:28], rnd2);
        2'd1: read_and_compare($sformatf("mixed load %0d", i), adr, rnd[29:28]);
        2'd2: fetch_word($sformatf("mixed fetch %0d", i), adr, 1'b0);
        default: fetch_during_load($sformatf("mixed pair %0d", i),
                                   XLEN'(rnd2[RAM_AW+1:0]), adr, rnd[29:28]);
      endcase
      check_flag($sformatf("mixed err_o %0d", i), 1'b0, err_o);
    end

    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

// File: mem_subsystem_top.f
rtl/bus_pkg.sv
rtl/lsu_pkg.sv
rtl/rv32i_memory_pipe.sv
rtl/fetch_port.sv
rtl/bus_arbiter.sv
rtl/slave_decoder.sv
rtl/wb_ram.sv
rtl/mem_subsystem_top.sv
bench/tb_mem_subsystem.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it
# A $fatal in the testbench gives a nonzero exit status
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module tb_mem_subsystem -f mem_subsystem_top.f
./obj_dir/Vtb_mem_subsystem
